//--- run_sim.sh
#!/usr/bin/env bash
# build and run the radio box testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rb_top -f src.f

# the log decides the result, so a stopped run still reaches the check
./obj_dir/Vtb_rb_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

//--- source/rb_input_mixer.sv
/*
 * input selector and gain stage
 * signed sample times unsigned gain, pipelined with a matching valid pipe
 */
`timescale 1ns/1ns

module rb_input_mixer import rb_signal_pkg::*; #(
  parameter int MIX_LAT = 3  // stages from input to output
) (
  input  logic                  clk_adc_125mhz,
  input  logic                  adc_rstn_i,
  input  logic                  rb_clk_en_i,
  input  logic                  rb_reset_n_i,
  input  logic [FAST_ADC_W-1:0] adc0_i,
  input  logic [FAST_ADC_W-1:0] adc1_i,
  input  logic [SAMPLE_W-1:0]   xadc_sample_i,
  input  logic [SRC_W-1:0]      muxin_src_i,
  input  logic [GAIN_W-1:0]     muxin_gain_i,
  output logic [SAMPLE_W-1:0]   mix_in_o,
  output logic [SAMPLE_W-1:0]   mix_out_o,
  output logic                  mix_vld_o
);

  localparam int PROD_W = SAMPLE_W + GAIN_W + 1;  // gain widened by a zero sign bit

  logic signed [PROD_W-1:0] product;
  logic        [PROD_W-1:0] prod_q [MIX_LAT];
  logic        [MIX_LAT-1:0] vld_q;

  // --------------------
  // source select
  // --------------------
  always_comb begin
    case (muxin_src_i)
      SRC_ADC0: mix_in_o = {~adc0_i, 2'b00};  // inverted front end, left aligned
      SRC_ADC1: mix_in_o = {~adc1_i, 2'b00};
      SRC_EXT0, SRC_EXT8, SRC_EXT1, SRC_EXT9, SRC_VPVN:
        mix_in_o = xadc_sample_i;
      default:  mix_in_o = '0;                // code 0 and unlisted codes
    endcase
  end

  assign product = $signed(mix_in_o) * $signed({1'b0, muxin_gain_i});

  // --------------------
  // product and valid pipe
  // --------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || !rb_reset_n_i) begin
      vld_q <= '0;                   // sub-block reset empties the pipe
      for (int i = 0; i < MIX_LAT; i++) begin
        prod_q[i] <= '0;
      end
    end else if (rb_clk_en_i) begin  // clock enable low holds everything
      prod_q[0] <= product;
      vld_q[0]  <= 1'b1;             // every enabled cycle is a sample
      for (int i = 1; i < MIX_LAT; i++) begin
        prod_q[i] <= prod_q[i-1];
        vld_q[i]  <= vld_q[i-1];
      end
    end
  end

  // sign, then product bits 31..17
  assign mix_out_o = {prod_q[MIX_LAT-1][PROD_W-1], prod_q[MIX_LAT-1][31:17]};
  assign mix_vld_o = vld_q[MIX_LAT-1];

endmodule

//--- source/rb_led_meter.sv
/*
 * LED magnitude meter
 * rate divided bar display of the selected input or the gain stage output
 */
`timescale 1ns/1ns

module rb_led_meter import rb_regs_pkg::*, rb_signal_pkg::*; #(
  parameter int LED_DIV_W = 20  // refresh every 2**LED_DIV_W cycles
) (
  input  logic                clk_adc_125mhz,
  input  logic                adc_rstn_i,
  input  logic                rb_reset_n_i,
  input  logic [3:0]          led_mode_i,
  input  logic [SAMPLE_W-1:0] mix_in_i,
  input  logic [SAMPLE_W-1:0] mix_out_i,
  output logic                rb_leds_en_o,
  output logic [7:0]          rb_leds_data_o
);

  logic [LED_DIV_W-1:0] led_cnt;  // refresh divider

  // upper nibble grows for positive values, lower nibble for negative
  function automatic logic [7:0] magnitude(input logic [SAMPLE_W-1:0] val);
    if (!val[15]) begin
      if (val[14])                magnitude = 8'hF0;
      else if (val[14:12] != '0)  magnitude = 8'h70;
      else if (val[14:10] != '0)  magnitude = 8'h30;
      else if (val != '0)         magnitude = 8'h10;
      else                        magnitude = 8'h00;  // exact zero
    end else begin
      if (!val[14])               magnitude = 8'h0F;
      else if (val[14:12] <= 3'd6) magnitude = 8'h0E;
      else if (val[14:10] <= 5'd30) magnitude = 8'h0C;
      else                        magnitude = 8'h08;  // just below zero
    end
  endfunction

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || !rb_reset_n_i) begin
      rb_leds_en_o   <= 1'b0;
      rb_leds_data_o <= '0;
      led_cnt        <= '0;
    end else if (led_mode_i != LED_DISABLED) begin
      rb_leds_en_o <= 1'b1;       // meter owns the LEDs
      if (led_cnt == '0) begin    // first active cycle, then once per wrap
        case (led_mode_i)
          LED_ADCIN_MAG: rb_leds_data_o <= magnitude(mix_in_i);
          LED_MIX_MAG:   rb_leds_data_o <= magnitude(mix_out_i);
          LED_OFF:       rb_leds_data_o <= '0;
          default:       rb_leds_data_o <= '0;  // dropped oscillator modes
        endcase
      end
      led_cnt <= led_cnt + 1'b1;
    end else begin
      rb_leds_en_o   <= 1'b0;     // disabled, hand LEDs back
      rb_leds_data_o <= '0;
      led_cnt        <= '0;
    end
  end

endmodule

//--- source/rb_power_seq.sv
/*
 * enable sequencer
 * power up raises the clock enable before releasing reset, power down reverses it
 */
`timescale 1ns/1ns

module rb_power_seq #(
  parameter int SEQ_WAIT = 3  // cycles between the two steps, minus one
) (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  input  logic rb_enable_i,
  output logic rb_clk_en_o,
  output logic rb_reset_n_o
);

  localparam int CNT_W = (SEQ_WAIT > 0) ? $clog2(SEQ_WAIT + 1) : 1;

  logic             enable_q;  // previous enable, for edge detect
  logic [CNT_W-1:0] wait_cnt;
  logic             enable_edge;

  assign enable_edge = rb_enable_i != enable_q;

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      enable_q     <= 1'b0;
      wait_cnt     <= '0;
      rb_clk_en_o  <= 1'b0;
      rb_reset_n_o <= 1'b0;
    end else begin
      enable_q <= rb_enable_i;
      if (enable_edge) begin
        wait_cnt <= CNT_W'(SEQ_WAIT);  // restart the wait on any change
        if (rb_enable_i) begin
          rb_clk_en_o <= 1'b1;         // first step up: clock on
        end else begin
          rb_reset_n_o <= 1'b0;        // first step down: hold in reset
        end
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (rb_enable_i) begin
        rb_reset_n_o <= 1'b1;          // second step up: release
      end else begin
        rb_clk_en_o <= 1'b0;           // second step down: clock off
      end
    end
  end

endmodule

//--- source/rb_regs.sv
/*
 * radio box register bank
 * system bus decode, write masks, status word and one cycle acknowledge
 */
`timescale 1ns/1ns

module rb_regs import rb_regs_pkg::*, rb_signal_pkg::*; (
  input  logic              clk_adc_125mhz,
  input  logic              adc_rstn_i,
  input  logic [31:0]       sys_addr_i,
  input  logic [31:0]       sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [31:0]       sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  input  logic              rb_clk_en_i,
  input  logic              rb_reset_n_i,
  input  logic              rb_leds_en_i,
  input  logic [7:0]        rb_leds_data_i,
  output logic              rb_enable_o,
  output logic [3:0]        led_mode_o,
  output logic [SRC_W-1:0]  muxin_src_o,
  output logic [GAIN_W-1:0] muxin_gain_o
);

  logic [RB_ADDR_W-1:0] addr;  // word offset within the block
  logic [31:0]          ctrl_q;
  logic                 clk_en_q;    // status copies, one cycle behind
  logic                 reset_n_q;
  logic                 leds_en_q;
  logic [7:0]           leds_q;
  logic [31:0]          status;
  logic [31:0]          rd_word;

  assign addr = sys_addr_i[RB_ADDR_W-1:0];

  // --------------------
  // write side
  // --------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ctrl_q       <= '0;
      led_mode_o   <= LED_DISABLED;
      muxin_src_o  <= '0;  // selects a zero input
      muxin_gain_o <= '0;
    end else if (sys_wen_i) begin
      case (addr)
        REG_CTRL:       ctrl_q       <= sys_wdata_i;
        REG_LED_CTRL:   led_mode_o   <= sys_wdata_i[3:0];        // mode nibble only
        REG_MUXIN_SRC:  muxin_src_o  <= sys_wdata_i[SRC_W-1:0];  // code bits only
        REG_MUXIN_GAIN: muxin_gain_o <= sys_wdata_i[GAIN_W-1:0];
        default: ;                                               // STATUS and holes ignore writes
      endcase
    end
  end

  assign rb_enable_o = ctrl_q[CTRL_ENABLE];

  // --------------------
  // status word
  // --------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      clk_en_q  <= 1'b0;
      reset_n_q <= 1'b0;
      leds_en_q <= 1'b0;
      leds_q    <= '0;
    end else begin
      clk_en_q  <= rb_clk_en_i;   // refreshed every cycle
      reset_n_q <= rb_reset_n_i;
      leds_en_q <= rb_leds_en_i;
      leds_q    <= rb_leds_data_i;
    end
  end

  always_comb begin
    status                      = '0;
    status[STAT_CLK_EN]         = clk_en_q;
    status[STAT_RESET]          = reset_n_q;  // set once the sub-block runs
    status[STAT_LEDS_EN]        = leds_en_q;
    status[STAT_LED_LSB +: 8]   = leds_q;
  end

  // --------------------
  // read side and acknowledge
  // --------------------
  always_comb begin
    case (addr)
      REG_CTRL:       rd_word = ctrl_q;
      REG_STATUS:     rd_word = status;
      REG_LED_CTRL:   rd_word = 32'(led_mode_o);   // upper bits read zero
      REG_MUXIN_SRC:  rd_word = 32'(muxin_src_o);
      REG_MUXIN_GAIN: rd_word = 32'(muxin_gain_o);
      default:        rd_word = '0;                 // unknown offsets read zero
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rd_word;  // valid together with the ack
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every request, known address or not
    end
  end

  assign sys_err_o = 1'b0;  // no error responses

endmodule

//--- source/rb_regs_pkg.sv
/*
 * radio box register map
 * bus offsets, control and status bit positions, LED meter modes
 */
package rb_regs_pkg;

  // -------------------
  // bus decode
  // -------------------
  localparam int unsigned RB_ADDR_W = 20;  // decoded address bits, one word per offset

  localparam logic [RB_ADDR_W-1:0] REG_CTRL       = 20'h00000;  // control, all bits kept
  localparam logic [RB_ADDR_W-1:0] REG_STATUS     = 20'h00004;  // read only
  localparam logic [RB_ADDR_W-1:0] REG_LED_CTRL   = 20'h0001C;  // LED meter mode
  localparam logic [RB_ADDR_W-1:0] REG_MUXIN_SRC  = 20'h00060;  // input selector code
  localparam logic [RB_ADDR_W-1:0] REG_MUXIN_GAIN = 20'h00064;  // input gain, unsigned

  // -------------------
  // control and status bits
  // -------------------
  localparam int unsigned CTRL_ENABLE = 0;  // enables the sub-block

  localparam int unsigned STAT_CLK_EN  = 0;   // sub-block clock enable
  localparam int unsigned STAT_RESET   = 1;   // sub-block reset released
  localparam int unsigned STAT_LEDS_EN = 2;   // meter owns the LEDs
  localparam int unsigned STAT_LED_LSB = 24;  // LED byte occupies 31..24

  // -------------------
  // LED meter modes
  // -------------------
  localparam logic [3:0] LED_DISABLED  = 4'd0;  // LEDs left to the board
  localparam logic [3:0] LED_OFF       = 4'd1;  // all LEDs dark
  localparam logic [3:0] LED_ADCIN_MAG = 4'd6;  // magnitude of the selected input
  localparam logic [3:0] LED_MIX_MAG   = 4'd7;  // magnitude of the gain stage output

endpackage

//--- source/rb_signal_pkg.sv
/*
 * radio box signal definitions
 * sample widths, input selector codes and XADC slot layout
 */
package rb_signal_pkg;

  localparam int unsigned SAMPLE_W   = 16;  // signed sample
  localparam int unsigned FAST_ADC_W = 14;  // fast ADC word
  localparam int unsigned GAIN_W     = 32;  // unsigned gain
  localparam int unsigned SRC_W      = 6;   // selector code
  localparam int unsigned XADC_TID_W = 5;   // XADC channel id

  // selector codes, XADC codes match the stream tid
  localparam logic [SRC_W-1:0] SRC_ADC0 = 6'h20;  // fast ADC channel A
  localparam logic [SRC_W-1:0] SRC_ADC1 = 6'h21;  // fast ADC channel B
  localparam logic [SRC_W-1:0] SRC_EXT0 = 6'h10;  // aux 0, sampled with aux 8
  localparam logic [SRC_W-1:0] SRC_EXT8 = 6'h18;
  localparam logic [SRC_W-1:0] SRC_EXT1 = 6'h11;  // aux 1, sampled with aux 9
  localparam logic [SRC_W-1:0] SRC_EXT9 = 6'h19;
  localparam logic [SRC_W-1:0] SRC_VPVN = 6'h03;  // dedicated Vp/Vn pair

  // slot order of the capture store
  localparam logic [2:0] XSLOT_CH8   = 3'd0;
  localparam logic [2:0] XSLOT_CH0   = 3'd1;
  localparam logic [2:0] XSLOT_CH1   = 3'd2;
  localparam logic [2:0] XSLOT_CH9   = 3'd3;
  localparam logic [2:0] XSLOT_VPVN  = 3'd4;
  localparam logic [2:0] XSLOT_COUNT = 3'd5;  // also marks "no slot"

endpackage

//--- source/rb_top.sv
/*
 * radio box signal input section
 * register bank, enable sequencer, XADC capture, gain stage and LED meter
 */
`timescale 1ns/1ns

module rb_top import rb_signal_pkg::*; #(
  parameter int LED_DIV_W = 20,  // LED refresh counter width
  parameter int SEQ_WAIT  = 3,   // sequencer wait cycles
  parameter int MIX_LAT   = 3    // gain stage depth
) (
  input  logic                  clk_adc_125mhz,
  input  logic                  adc_rstn_i,
  input  logic [FAST_ADC_W-1:0] adc0_i,
  input  logic [FAST_ADC_W-1:0] adc1_i,
  input  logic [31:0]           sys_addr_i,
  input  logic [31:0]           sys_wdata_i,
  input  logic [3:0]            sys_sel_i,   // byte select, full words only
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [31:0]           sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  input  logic [SAMPLE_W-1:0]   xadc_tdata_i,
  input  logic [XADC_TID_W-1:0] xadc_tid_i,
  input  logic                  xadc_tvalid_i,
  output logic                  xadc_tready_o,
  output logic                  rb_en_o,      // gain stage output valid
  output logic [SAMPLE_W-1:0]   rb_out_o,
  output logic                  rb_leds_en_o,
  output logic [7:0]            rb_leds_data_o
);

  logic                rb_enable;   // CTRL enable bit
  logic                rb_clk_en;   // sub-block clock enable
  logic                rb_reset_n;  // sub-block reset, active low
  logic [3:0]          led_mode;
  logic [SRC_W-1:0]    muxin_src;
  logic [GAIN_W-1:0]   muxin_gain;
  logic [SAMPLE_W-1:0] xadc_sample;  // slot picked by the selector
  logic [SAMPLE_W-1:0] mix_in;       // selected input before gain

  rb_regs u_regs (
    .clk_adc_125mhz, .adc_rstn_i,
    .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_ack_o, .sys_err_o,
    .rb_clk_en_i    (rb_clk_en),
    .rb_reset_n_i   (rb_reset_n),
    .rb_leds_en_i   (rb_leds_en_o),
    .rb_leds_data_i (rb_leds_data_o),
    .rb_enable_o    (rb_enable),
    .led_mode_o     (led_mode),
    .muxin_src_o    (muxin_src),
    .muxin_gain_o   (muxin_gain)
  );

  rb_power_seq #(.SEQ_WAIT(SEQ_WAIT)) u_power_seq (
    .clk_adc_125mhz, .adc_rstn_i,
    .rb_enable_i  (rb_enable),
    .rb_clk_en_o  (rb_clk_en),
    .rb_reset_n_o (rb_reset_n)
  );

  rb_xadc_capture u_xadc_capture (
    .clk_adc_125mhz, .adc_rstn_i,
    .xadc_tdata_i, .xadc_tid_i, .xadc_tvalid_i, .xadc_tready_o,
    .muxin_src_i   (muxin_src),
    .xadc_sample_o (xadc_sample)
  );

  rb_input_mixer #(.MIX_LAT(MIX_LAT)) u_input_mixer (
    .clk_adc_125mhz, .adc_rstn_i,
    .rb_clk_en_i   (rb_clk_en),
    .rb_reset_n_i  (rb_reset_n),
    .adc0_i, .adc1_i,
    .xadc_sample_i (xadc_sample),
    .muxin_src_i   (muxin_src),
    .muxin_gain_i  (muxin_gain),
    .mix_in_o      (mix_in),
    .mix_out_o     (rb_out_o),
    .mix_vld_o     (rb_en_o)
  );

  rb_led_meter #(.LED_DIV_W(LED_DIV_W)) u_led_meter (
    .clk_adc_125mhz, .adc_rstn_i,
    .rb_reset_n_i  (rb_reset_n),
    .led_mode_i    (led_mode),
    .mix_in_i      (mix_in),
    .mix_out_i     (rb_out_o),
    .rb_leds_en_o, .rb_leds_data_o
  );

endmodule

//--- source/rb_xadc_capture.sv
/*
 * XADC sample store
 * keeps the latest stream sample per channel id, presents the selected slot
 */
`timescale 1ns/1ns

module rb_xadc_capture import rb_signal_pkg::*; (
  input  logic                  clk_adc_125mhz,
  input  logic                  adc_rstn_i,
  input  logic [SAMPLE_W-1:0]   xadc_tdata_i,
  input  logic [XADC_TID_W-1:0] xadc_tid_i,
  input  logic                  xadc_tvalid_i,
  input  logic [SRC_W-1:0]      muxin_src_i,
  output logic                  xadc_tready_o,
  output logic [SAMPLE_W-1:0]   xadc_sample_o
);

  logic [SAMPLE_W-1:0] slot_q [XSLOT_COUNT];
  logic [2:0]          tid_slot;  // slot of the incoming beat
  logic [2:0]          sel_slot;  // slot named by the selector

  // tid and selector share one code space
  function automatic logic [2:0] slot_of(input logic [SRC_W-1:0] code);
    case (code)
      SRC_EXT8: slot_of = XSLOT_CH8;
      SRC_EXT0: slot_of = XSLOT_CH0;
      SRC_EXT1: slot_of = XSLOT_CH1;
      SRC_EXT9: slot_of = XSLOT_CH9;
      SRC_VPVN: slot_of = XSLOT_VPVN;
      default:  slot_of = XSLOT_COUNT;  // not an XADC channel
    endcase
  endfunction

  assign tid_slot = slot_of(SRC_W'(xadc_tid_i));
  assign sel_slot = slot_of(muxin_src_i);

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      xadc_tready_o <= 1'b0;
      for (int i = 0; i < XSLOT_COUNT; i++) begin
        slot_q[i] <= '0;
      end
    end else begin
      xadc_tready_o <= 1'b1;  // always ready after reset
      if (xadc_tvalid_i && xadc_tready_o && tid_slot != XSLOT_COUNT) begin
        slot_q[tid_slot] <= xadc_tdata_i;  // unknown tids dropped
      end
    end
  end

  assign xadc_sample_o = (sel_slot == XSLOT_COUNT) ? '0 : slot_q[sel_slot];

endmodule

//--- src.f
source/rb_regs_pkg.sv
source/rb_signal_pkg.sv
source/rb_regs.sv
source/rb_power_seq.sv
source/rb_xadc_capture.sv
source/rb_input_mixer.sv
source/rb_led_meter.sv
source/rb_top.sv
testbench/rb_top_assert.sv
testbench/tb_rb_top.sv

//--- testbench/rb_top_assert.sv
/*
 * bus and sequencer checks bound to the radio box top level
 */
`timescale 1ns/1ns

module rb_top_assert (
  input logic clk_i,
  input logic rstn_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i,
  input logic en_i,      // gain stage output valid
  input logic reset_n_i  // sub-block reset, status copy is one cycle behind
);

  ack_after_request: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (wen_i || ren_i) |=> ack_i)
    else $error("acknowledge missing one cycle after a request");

  no_error_response: assert property (@(posedge clk_i) disable iff (!rstn_i) !err_i)
    else $error("bus error response seen");

  valid_needs_release: assert property (@(posedge clk_i) disable iff (!rstn_i)
    en_i |-> $past(reset_n_i))
    else $error("output valid while status shows the sub-block in reset");

endmodule

bind rb_top rb_top_assert u_top_assert (
  .clk_i     (clk_adc_125mhz),
  .rstn_i    (adc_rstn_i),
  .wen_i     (sys_wen_i),
  .ren_i     (sys_ren_i),
  .ack_i     (sys_ack_o),
  .err_i     (sys_err_o),
  .en_i      (rb_en_o),
  .reset_n_i (rb_reset_n)
);

//--- testbench/tb_rb_top.sv
/*
 * testbench for the radio box signal input section
 * directed register, sequencer, datapath and LED meter tests
 */
`timescale 1ns/1ns

module tb_rb_top import rb_regs_pkg::*, rb_signal_pkg::*; ();

  localparam int LED_DIV_W  = 4;
  localparam int SEQ_WAIT   = 3;
  localparam int MIX_LAT    = 3;
  localparam int MAX_CYCLES = 3000;               // tests need about 200 cycles
  localparam logic [31:0] RB_BASE = 32'h4060_0000;  // upper bits not decoded

  logic                  clk_adc_125mhz = 1'b0;
  logic                  adc_rstn_i;
  logic [FAST_ADC_W-1:0] adc0_i;
  logic [FAST_ADC_W-1:0] adc1_i;
  logic [31:0]           sys_addr_i;
  logic [31:0]           sys_wdata_i;
  logic [3:0]            sys_sel_i;
  logic                  sys_wen_i;
  logic                  sys_ren_i;
  logic [31:0]           sys_rdata_o;
  logic                  sys_ack_o;
  logic                  sys_err_o;
  logic [SAMPLE_W-1:0]   xadc_tdata_i;
  logic [XADC_TID_W-1:0] xadc_tid_i;
  logic                  xadc_tvalid_i;
  logic                  xadc_tready_o;
  logic                  rb_en_o;
  logic [SAMPLE_W-1:0]   rb_out_o;
  logic                  rb_leds_en_o;
  logic [7:0]            rb_leds_data_o;

  integer seed;
  int     err_cnt   = 0;  // wrong values
  int     fault_cnt = 0;  // protocol and timing failures
  int     check_cnt = 0;
  int     cycle_cnt = 0;

  rb_top #(.LED_DIV_W(LED_DIV_W), .SEQ_WAIT(SEQ_WAIT), .MIX_LAT(MIX_LAT)) dut0 (.*);

  always #4 clk_adc_125mhz = ~clk_adc_125mhz;  // 125 MHz

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] reg_addr(input logic [RB_ADDR_W-1:0] off);
    return RB_BASE | 32'(off);
  endfunction

  // signed sample times unsigned gain, then sign and bits 31..17
  function automatic logic [15:0] mix_expect(input logic [15:0] in, input logic [31:0] gain);
    longint s;
    longint g;
    longint p;
    s = longint'($signed(in));
    g = longint'({32'd0, gain});
    p = s * g;
    return {p[63], p[31:17]};
  endfunction

  // expected LED byte, upper nibble for positive, lower for negative
  function automatic logic [7:0] led_level(input logic [15:0] v);
    logic [14:0] m;
    m = v[14:0];
    if (!v[15]) begin
      if (m >= 15'h4000) return 8'hF0;
      if (m >= 15'h1000) return 8'h70;
      if (m >= 15'h0400) return 8'h30;
      if (m != '0) return 8'h10;
      return 8'h00;
    end
    if (m < 15'h4000) return 8'h0F;
    if (m < 15'h7000) return 8'h0E;
    if (m < 15'h7C00) return 8'h0C;
    return 8'h08;
  endfunction

  task automatic report_fault(input string what);
    fault_cnt++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_adc_125mhz);
  endtask

  // one cycle request, ack checked on the next falling edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(negedge clk_adc_125mhz);
    sys_wen_i   = 1'b0;
    assert (sys_ack_o === 1'b1) else report_fault("no acknowledge one cycle after a write");
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(negedge clk_adc_125mhz);
    sys_ren_i  = 1'b0;
    assert (sys_ack_o === 1'b1) else report_fault("no acknowledge one cycle after a read");
    data = sys_rdata_o;
  endtask

  task automatic send_beat(input logic [XADC_TID_W-1:0] tid, input logic [SAMPLE_W-1:0] data);
    xadc_tid_i    = tid;
    xadc_tdata_i  = data;
    xadc_tvalid_i = 1'b1;
    assert (xadc_tready_o === 1'b1) else report_fault("XADC stream not ready");
    @(negedge clk_adc_125mhz);
    xadc_tvalid_i = 1'b0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (rb_en_o !== 1'b1 && n < 20) begin
      @(negedge clk_adc_125mhz);
      n++;
    end
    assert (rb_en_o === 1'b1) else report_fault("gain stage output never became valid");
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_registers();
    logic [31:0] d;
    logic [31:0] r;
    d = $random(seed) & ~32'h1;  // enable stays off here
    bus_write(reg_addr(REG_CTRL), d);
    bus_read(reg_addr(REG_CTRL), r);
    compare_word("CTRL", r, d);
    d = $random(seed);
    bus_write(reg_addr(REG_LED_CTRL), d);
    bus_read(reg_addr(REG_LED_CTRL), r);
    compare_word("LED_CTRL", r, d & 32'hF);
    d = $random(seed);
    bus_write(reg_addr(REG_MUXIN_SRC), d);
    bus_read(reg_addr(REG_MUXIN_SRC), r);
    compare_word("MUXIN_SRC", r, d & 32'h3F);
    d = $random(seed);
    bus_write(reg_addr(REG_MUXIN_GAIN), d);
    bus_read(reg_addr(REG_MUXIN_GAIN), r);
    compare_word("MUXIN_GAIN", r, d);
    bus_read(RB_BASE | 32'h0000_0040, r);  // hole in the map
    compare_word("unmapped word", r, 32'h0);
    bus_write(reg_addr(REG_CTRL), 32'h0);
    bus_write(reg_addr(REG_LED_CTRL), 32'h0);
    bus_write(reg_addr(REG_MUXIN_SRC), 32'h0);
  endtask

  task automatic test_sequencer();
    logic [31:0] st;
    int          polls;
    bit          clk_first;
    bit          rst_first;
    bus_write(reg_addr(REG_CTRL), 32'h1);
    polls     = 0;
    clk_first = 1'b0;
    st        = '0;
    while (!(st[STAT_CLK_EN] && st[STAT_RESET]) && polls < 12) begin
      bus_read(reg_addr(REG_STATUS), st);
      polls++;
      if (st[STAT_CLK_EN] && !st[STAT_RESET]) clk_first = 1'b1;  // clock on, still in reset
    end
    assert (st[STAT_CLK_EN] && st[STAT_RESET])
      else report_fault("sub-block not running within 12 cycles of enable");
    assert (clk_first) else report_fault("reset released before the clock enable was seen");
    bus_write(reg_addr(REG_CTRL), 32'h0);
    polls     = 0;
    rst_first = 1'b0;
    st        = 32'h3;
    while ((st[STAT_CLK_EN] || st[STAT_RESET]) && polls < 12) begin
      bus_read(reg_addr(REG_STATUS), st);
      polls++;
      if (st[STAT_CLK_EN] && !st[STAT_RESET]) rst_first = 1'b1;  // in reset, clock still on
    end
    assert (!st[STAT_CLK_EN] && !st[STAT_RESET])
      else report_fault("sub-block not shut down within 12 cycles of disable");
    assert (rst_first) else report_fault("clock enable dropped before the reset");
    compare_word("rb_en_o", 32'(rb_en_o), 32'h0);
  endtask

  task automatic test_fast_adc();
    logic [31:0]      rnd;
    logic [31:0]      gain;
    logic [15:0]      in;
    logic [SRC_W-1:0] codes [2];
    codes = '{SRC_ADC0, SRC_ADC1};
    bus_write(reg_addr(REG_CTRL), 32'h1);  // stays enabled for the rest
    wait_valid();
    for (int i = 0; i < 2; i++) begin
      rnd    = $random(seed);
      adc0_i = rnd[13:0];
      adc1_i = rnd[29:16];
      gain   = $random(seed);
      bus_write(reg_addr(REG_MUXIN_SRC), 32'(codes[i]));
      bus_write(reg_addr(REG_MUXIN_GAIN), gain);
      wait_cycles(MIX_LAT);
      in = (i == 0) ? {~adc0_i, 2'b00} : {~adc1_i, 2'b00};  // inverted, two zero bits
      compare_word("rb_out_o", 32'(rb_out_o), 32'(mix_expect(in, gain)));
    end
  endtask

  task automatic test_xadc();
    logic [31:0]           rnd;
    logic [31:0]           gain;
    logic [XADC_TID_W-1:0] tids [3];
    logic [15:0]           samples [3];
    tids = '{5'h10, 5'h18, 5'h03};
    for (int i = 0; i < 3; i++) begin
      rnd        = $random(seed);
      samples[i] = rnd[15:0];
      send_beat(tids[i], samples[i]);
    end
    rnd = $random(seed);
    send_beat(5'h07, rnd[15:0]);  // no slot for this id
    gain = $random(seed);
    bus_write(reg_addr(REG_MUXIN_GAIN), gain);
    for (int i = 0; i < 3; i++) begin
      bus_write(reg_addr(REG_MUXIN_SRC), 32'(tids[i]));
      wait_cycles(MIX_LAT);
      compare_word("rb_out_o", 32'(rb_out_o), 32'(mix_expect(samples[i], gain)));
    end
  endtask

  task automatic test_led_meter();
    logic [31:0] rnd;
    logic [31:0] st;
    logic [15:0] vals [2];
    logic [7:0]  exp;
    rnd     = $random(seed);
    vals[0] = {1'b0, rnd[14:0]};   // positive
    vals[1] = {1'b1, rnd[30:16]};  // negative
    bus_write(reg_addr(REG_MUXIN_SRC), 32'(SRC_EXT0));
    bus_write(reg_addr(REG_LED_CTRL), 32'(LED_ADCIN_MAG));
    for (int i = 0; i < 2; i++) begin
      send_beat(5'h10, vals[i]);
      wait_cycles((1 << LED_DIV_W) + 1);  // one full refresh period
      exp = led_level(vals[i]);
      compare_word("rb_leds_en_o", 32'(rb_leds_en_o), 32'h1);
      compare_word("rb_leds_data_o", 32'(rb_leds_data_o), 32'(exp));
      bus_read(reg_addr(REG_STATUS), st);
      compare_word("STATUS LED enable", 32'(st[STAT_LEDS_EN]), 32'h1);
      compare_word("STATUS LED byte", 32'(st[STAT_LED_LSB +: 8]), 32'(exp));
    end
    bus_write(reg_addr(REG_LED_CTRL), 32'(LED_OFF));
    wait_cycles((1 << LED_DIV_W) + 1);
    compare_word("rb_leds_en_o", 32'(rb_leds_en_o), 32'h1);
    compare_word("rb_leds_data_o", 32'(rb_leds_data_o), 32'h0);
    bus_write(reg_addr(REG_LED_CTRL), 32'(LED_DISABLED));
    wait_cycles(2);  // meter clears, then status copy follows
    compare_word("rb_leds_en_o", 32'(rb_leds_en_o), 32'h0);
    compare_word("rb_leds_data_o", 32'(rb_leds_data_o), 32'h0);
    bus_read(reg_addr(REG_STATUS), st);
    compare_word("STATUS LED enable", 32'(st[STAT_LEDS_EN]), 32'h0);
    compare_word("STATUS LED byte", 32'(st[STAT_LED_LSB +: 8]), 32'h0);
  endtask

  // --------------------
  // run control
  // --------------------
  always @(posedge clk_adc_125mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    seed          = 32'h3ba7f6da;
    adc_rstn_i    = 1'b0;
    adc0_i        = '0;
    adc1_i        = '0;
    sys_addr_i    = '0;
    sys_wdata_i   = '0;
    sys_sel_i     = 4'hF;
    sys_wen_i     = 1'b0;
    sys_ren_i     = 1'b0;
    xadc_tdata_i  = '0;
    xadc_tid_i    = '0;
    xadc_tvalid_i = 1'b0;
    repeat (4) @(negedge clk_adc_125mhz);  // four reset cycles
    adc_rstn_i = 1'b1;
    @(negedge clk_adc_125mhz);
    test_registers();
    test_sequencer();
    test_fast_adc();
    test_xadc();
    test_led_meter();
    $display("checks: %0d, value errors: %0d, other errors: %0d", check_cnt, err_cnt, fault_cnt);
    if (err_cnt == 0 && fault_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
